// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build vreadTb with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module vreadTb -Mdir obj_dir -o vreadSim
	./obj_dir/vreadSim

clean:
	rm -rf obj_dir

// File: common/addrGenPkg.sv
`default_nettype none

package addrGenPkg;

   // buffer word address, msb picks the ping-pong half
   localparam int BUF_ADDR_W = 8;

   // period and duty counters
   localparam int PERIOD_W = 10;

   localparam int DELAY_W = 10;

   // addresses, starts, increments, shifts and iteration counts
   typedef logic [BUF_ADDR_W-1:0] bufAddrT;

   typedef logic [PERIOD_W-1:0] periodT;

   typedef logic [DELAY_W-1:0] delayT;

endpackage

`default_nettype wire

// File: common/busPkg.sv
`default_nettype none

package busPkg;

   // external bus, byte addressed
   localparam int BUS_ADDR_W = 32;
   localparam int BUS_DATA_W = 32;

   typedef logic [BUS_ADDR_W-1:0] busAddrT;

   // bus beat, same width as a buffer word
   typedef logic [BUS_DATA_W-1:0] busDataT;

endpackage

`default_nettype wire

// File: project.f
common/busPkg.sv
common/addrGenPkg.sv
vread/vreadCtrl.sv
vread/burstAddrGen.sv
vread/memoryWriter.sv
vread/patternAddrGen.sv
vread/readAligner.sv
src/dualPortBuffer.sv
src/vreadTop.sv
verif/vreadTb.sv

// File: src/dualPortBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module dualPortBuffer (
   input  logic                clk,
   input  logic                writeEn,
   input  addrGenPkg::bufAddrT writeAddr,
   input  busPkg::busDataT     writeData,
   input  logic                readEn,
   input  addrGenPkg::bufAddrT readAddr,
   output busPkg::busDataT     readData
);
   import busPkg::*;
   import addrGenPkg::*;

   localparam int DEPTH = 2 ** BUF_ADDR_W;

   // both ping-pong halves
   busDataT mem [DEPTH];

   always_ff @(posedge clk) begin
      if (writeEn) begin
         mem[writeAddr] <= writeData;
      end
   end

   // read data holds between reads
   always_ff @(posedge clk) begin
      if (readEn) begin
         readData <= mem[readAddr];
      end
   end

endmodule

`default_nettype wire

// File: src/vreadTop.sv
`timescale 1ns/1ps
`default_nettype none

module vreadTop #(
   parameter int DATA_W = 8
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  logic                disabled,
   input  logic                pingPong,
   input  logic                reverseB,
   // bus
   input  busPkg::busAddrT     extAddr,
   input  logic                busReady,
   input  logic                busLast,
   input  busPkg::busDataT     busRdata,
   // write side
   input  addrGenPkg::periodT  perA,
   input  addrGenPkg::bufAddrT incrA,
   // read side
   input  addrGenPkg::bufAddrT startB,
   input  addrGenPkg::bufAddrT incrB,
   input  addrGenPkg::bufAddrT shiftB,
   input  addrGenPkg::bufAddrT iterB,
   input  addrGenPkg::periodT  perB,
   input  addrGenPkg::periodT  dutyB,
   input  addrGenPkg::bufAddrT iter2B,
   input  addrGenPkg::bufAddrT shift2B,
   input  addrGenPkg::bufAddrT incr2B,
   input  addrGenPkg::delayT   delay0,
   output logic                busValid,
   output busPkg::busAddrT     busAddr,
   output logic                done,
   output logic [DATA_W-1:0]   dataOut,
   output logic                outValid
);
   import busPkg::*;
   import addrGenPkg::*;

   logic    go;
   logic    dataReady;
   logic    genDone;
   bufAddrT writeStart;
   bufAddrT readStart;

   logic    genValid;
   logic    genReady;
   bufAddrT genAddr;

   logic    memWrite;
   bufAddrT wrAddr;
   busDataT wrData;

   bufAddrT patAddr;
   logic    patReadEn;
   bufAddrT rdAddr;
   logic    rdEn;
   busDataT rdData;

   vreadCtrl uCtrl (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .disabled   (disabled),
      .pingPong   (pingPong),
      .extAddr    (extAddr),
      .startB     (startB),
      .busLast    (busLast),
      .busReady   (busReady),
      .dataReady  (dataReady),
      .genDone    (genDone),
      .go         (go),
      .done       (done),
      .busValid   (busValid),
      .busAddr    (busAddr),
      .writeStart (writeStart),
      .readStart  (readStart)
   );

   burstAddrGen uWriteGen (
      .clk    (clk),
      .rst    (rst),
      .go     (go),
      .period (perA),
      .start  (writeStart),
      .incr   (incrA),
      .ready  (genReady),
      .valid  (genValid),
      .addr   (genAddr)
   );

   memoryWriter uWriter (
      .clk       (clk),
      .rst       (rst),
      .genValid  (genValid),
      .genAddr   (genAddr),
      .busReady  (busReady),
      .busRdata  (busRdata),
      .busValid  (busValid),
      .genReady  (genReady),
      .dataReady (dataReady),
      .memWrite  (memWrite),
      .memAddr   (wrAddr),
      .memData   (wrData)
   );

   patternAddrGen uReadGen (
      .clk         (clk),
      .rst         (rst),
      .go          (go),
      .start       (readStart),
      .incr        (incrB),
      .shift       (shiftB),
      .shift2      (shift2B),
      .incr2       (incr2B),
      .iterations  (iterB),
      .iterations2 (iter2B),
      .period      (perB),
      .duty        (dutyB),
      .delay       (delay0),
      .addr        (patAddr),
      .readEn      (patReadEn),
      .genDone     (genDone)
   );

   readAligner #(
      .DATA_W (DATA_W)
   ) uAligner (
      .clk      (clk),
      .rst      (rst),
      .addrIn   (patAddr),
      .readEn   (patReadEn),
      .reverse  (reverseB),
      .pingPong (pingPong),
      .memData  (rdData),
      .memAddr  (rdAddr),
      .memRead  (rdEn),
      .dataOut  (dataOut),
      .outValid (outValid)
   );

   dualPortBuffer uBuffer (
      .clk       (clk),
      .writeEn   (memWrite),
      .writeAddr (wrAddr),
      .writeData (wrData),
      .readEn    (rdEn),
      .readAddr  (rdAddr),
      .readData  (rdData)
   );

endmodule

`default_nettype wire

// File: verif/vreadTb.sv
`timescale 1ns/1ps
`default_nettype none

module vreadTb;
   import busPkg::*;
   import addrGenPkg::*;

   localparam int DATA_W = 8;
   localparam int RATIO = BUS_DATA_W / DATA_W;
   localparam int SEL_W = $clog2(RATIO);
   localparam int HALF = 2 ** (BUF_ADDR_W - 1);
   localparam int DISABLED_WINDOW = 64;

   logic              clk;
   logic              rst;
   logic              run;
   logic              disabled;
   logic              pingPong;
   logic              reverseB;
   busAddrT           extAddr;
   logic              busReady;
   logic              busLast;
   busDataT           busRdata;
   periodT            perA;
   bufAddrT           incrA;
   bufAddrT           startB;
   bufAddrT           incrB;
   bufAddrT           shiftB;
   bufAddrT           iterB;
   periodT            perB;
   periodT            dutyB;
   bufAddrT           iter2B;
   bufAddrT           shift2B;
   bufAddrT           incr2B;
   delayT             delay0;
   logic              busValid;
   busAddrT           busAddr;
   logic              done;
   logic [DATA_W-1:0] dataOut;
   logic              outValid;

   // fields of the test line in use
   string   curName;
   int      tPingPong, tReverse, tDisabled;
   int      tBurst, tPerA, tIncrA;
   int      tStartB, tIncrB, tShiftB, tIterB, tPerB, tDutyB;
   int      tIter2B, tShift2B, tIncr2B, tDelay;
   busDataT tSeed;

   // bus model, current burst
   int      beatIdx;
   int      curBurst;
   int      curIncrA;
   busDataT curSeed;
   bufAddrT curWriteBase;

   busDataT           refMem [2 ** BUF_ADDR_W];
   logic              tbPpState;
   logic [DATA_W-1:0] expQ [$];
   string             testLines [$];
   int                limitCycles;

   vreadTop #(
      .DATA_W (DATA_W)
   ) u_dut (.*);

   function automatic int atLeastOne(input int v);
      return (v < 1) ? 1 : v;
   endfunction

   function automatic bufAddrT flipBits(input bufAddrT a);
      return {<<{a}};
   endfunction

   function automatic busDataT beatData(input int k);
      return curSeed + busDataT'(k) * busDataT'(32'h0101_0101);
   endfunction

   function automatic int stepCount();
      return atLeastOne(tIter2B) * atLeastOne(tIterB) * atLeastOne(tPerB);
   endfunction

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s %s: expected %h, actual %h", curName, what, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   task automatic abortRun(input string why);
      $display("%s (test %s)", why, curName);
      $display(">>> FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic parseLine(input string line);
      int n;
      n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %h",
         curName, tPingPong, tReverse, tDisabled, tBurst, tPerA, tIncrA, tStartB, tIncrB,
         tShiftB, tIterB, tPerB, tDutyB, tIter2B, tShift2B, tIncr2B, tDelay, tSeed);
      if (n != 18) begin
         abortRun("malformed line in verif/vreadTests.txt");
      end
   endtask

   // expected symbols of one run, in issue order
   task automatic predictReads(input bufAddrT base);
      bufAddrT symAddr;
      bufAddrT wordAddr;
      busDataT word;
      int      sel;
      for (int o = 0; o < atLeastOne(tIter2B); o++) begin
         for (int i = 0; i < atLeastOne(tIterB); i++) begin
            for (int p = 0; p < atLeastOne(tPerB); p++) begin
               if (p < tDutyB) begin
                  symAddr = bufAddrT'(base + o * tShift2B + i * tShiftB + p * tIncrB);
                  if (tReverse != 0) begin
                     symAddr = flipBits(symAddr);
                  end
                  if (RATIO > 1) begin
                     wordAddr = (symAddr & bufAddrT'(HALF - 1)) >> SEL_W;
                     wordAddr[BUF_ADDR_W-1] = tPingPong[0] & symAddr[BUF_ADDR_W-1];
                     sel = int'(symAddr) % RATIO;
                  end else begin
                     wordAddr = symAddr;
                     sel = 0;
                  end
                  word = refMem[wordAddr];
                  expQ.push_back(word[sel*DATA_W +: DATA_W]);
               end
            end
         end
      end
   endtask

   task automatic runTest(input int idx, input string line);
      bufAddrT readBase;
      bufAddrT writeBase;
      parseLine(line);
      // read half follows the ping-pong state before this run
      readBase = bufAddrT'(tStartB);
      if (tPingPong != 0) begin
         readBase[BUF_ADDR_W-1] = tbPpState;
      end
      writeBase = '0;
      writeBase[BUF_ADDR_W-1] = ~tbPpState;
      @(posedge clk);
      pingPong <= tPingPong[0];
      reverseB <= tReverse[0];
      disabled <= tDisabled[0];
      extAddr  <= 32'h4000_0000 + busAddrT'(idx) * 32'h1000;
      perA     <= periodT'(tPerA);
      incrA    <= bufAddrT'(tIncrA);
      startB   <= bufAddrT'(tStartB);
      incrB    <= bufAddrT'(tIncrB);
      shiftB   <= bufAddrT'(tShiftB);
      iterB    <= bufAddrT'(tIterB);
      perB     <= periodT'(tPerB);
      dutyB    <= periodT'(tDutyB);
      iter2B   <= bufAddrT'(tIter2B);
      shift2B  <= bufAddrT'(tShift2B);
      incr2B   <= bufAddrT'(tIncr2B);
      delay0   <= delayT'(tDelay);
      beatIdx = 0;
      if (tDisabled != 0) begin
         curBurst = 0;
      end else begin
         curBurst = tBurst;
         curIncrA = tIncrA;
         curSeed = tSeed;
         curWriteBase = writeBase;
         predictReads(readBase);
         tbPpState = tPingPong[0] & ~tbPpState;
      end
      @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      if (tDisabled != 0) begin
         repeat (DISABLED_WINDOW) begin
            @(negedge clk);
            checkValue("done while disabled", 1, done);
            checkValue("busValid while disabled", 0, busValid);
            checkValue("outValid while disabled", 0, outValid);
         end
      end else begin
         @(negedge clk);
         checkValue("done after go", 0, done);
         checkValue("busAddr after go", extAddr, busAddr);
         while (done !== 1'b1) begin
            @(negedge clk);
         end
         @(posedge clk);
         checkValue("beats before done", curBurst, beatIdx);
         checkValue("reads left at done", 0, expQ.size());
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // bus slave with random back-pressure
   initial begin : busModel
      void'($urandom(17073));
      busReady <= 1'b0;
      busLast  <= 1'b0;
      busRdata <= '0;
      forever begin
         @(posedge clk);
         busReady <= ($urandom % 4) != 0;
         busRdata <= beatData(beatIdx);
         busLast  <= (beatIdx == curBurst - 1);
      end
   end

   // transfers update the reference buffer, outputs pop the expected queue
   always @(negedge clk) begin
      if (rst === 1'b0) begin
         if (busValid && busReady) begin
            if (beatIdx >= curBurst) begin
               abortRun("bus beat transferred outside a burst");
            end else begin
               refMem[bufAddrT'(curWriteBase + beatIdx * curIncrA)] = beatData(beatIdx);
               beatIdx++;
            end
         end
         if (outValid) begin
            if (expQ.size() == 0) begin
               abortRun("outValid with no read pending");
            end else begin
               checkValue("dataOut", expQ.pop_front(), dataOut);
            end
         end
      end
   end

   initial begin : watchdog
      wait (limitCycles > 0);
      repeat (limitCycles) @(posedge clk);
      $display("timeout after %0d cycles, the tests did not complete", limitCycles);
      $display(">>> FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin : mainSeq
      int    fd;
      int    total;
      string line;
      rst      <= 1'b1;
      run      <= 1'b0;
      disabled <= 1'b0;
      pingPong <= 1'b0;
      reverseB <= 1'b0;
      extAddr  <= '0;
      perA     <= '0;
      incrA    <= '0;
      startB   <= '0;
      incrB    <= '0;
      shiftB   <= '0;
      iterB    <= '0;
      perB     <= '0;
      dutyB    <= '0;
      iter2B   <= '0;
      shift2B  <= '0;
      incr2B   <= '0;
      delay0   <= '0;
      tbPpState = 1'b0;
      curName = "setup";
      fd = $fopen("verif/vreadTests.txt", "r");
      if (fd == 0) begin
         abortRun("cannot open verif/vreadTests.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
            testLines.push_back(line);
         end
      end
      $fclose(fd);
      total = 0;
      foreach (testLines[t]) begin
         parseLine(testLines[t]);
         total += tDelay + tBurst * (tPerA + 8) + stepCount();
      end
      limitCycles = 4 * total + 1000;
      curName = "reset";
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checkValue("done after reset", 1, done);
      checkValue("busValid after reset", 0, busValid);
      checkValue("outValid after reset", 0, outValid);
      foreach (testLines[t]) begin
         runTest(t, testLines[t]);
      end
      // a few idle cycles to catch stray outputs
      repeat (8) @(negedge clk);
      @(posedge clk);
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/vreadTests.txt
# name pingPong reverseB disabled burstLen perA incrA startB incrB shiftB iterB perB dutyB
#      iter2B shift2B incr2B delay0 seed   (seed in hex, all other columns decimal)
fillFirst     1 0 0 32 1 1 0  1 0  1 1   0   1 0  0 0 11223344
fillRead      1 0 0 32 2 1 0  1 0  1 128 128 1 0  0 0 a0b1c2d3
patternRead   1 0 0 32 3 1 5  3 20 3 6   4   2 50 7 9 5f000010
pingPongThird 1 0 0 32 1 1 16 5 1  2 8   8   1 0  0 0 3c3c0000
reverseRead   0 1 0 32 4 1 0  1 32 4 32  32  1 0  0 3 12345678
disabledRun   0 0 1 32 1 1 0  1 0  1 4   4   1 0  0 0 deadbeef
reverseStride 0 1 0 16 2 2 3  7 11 2 20  15  2 40 0 2 0f0e0d0c
finalPingPong 1 0 0 32 1 1 64 2 9  3 10  7   1 0  5 1 77665544

// File: vread/burstAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module burstAddrGen (
   input  logic                clk,
   input  logic                rst,
   input  logic                go,
   input  addrGenPkg::periodT  period,
   input  addrGenPkg::bufAddrT start,
   input  addrGenPkg::bufAddrT incr,
   input  logic                ready,
   output logic                valid,
   output addrGenPkg::bufAddrT addr
);
   import addrGenPkg::*;

   // cycles left before the next address shows up
   periodT waitCnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid   <= 1'b0;
         waitCnt <= '0;
      end else if (go) begin
         valid   <= 1'b1;
         waitCnt <= '0;
      end else if (valid && ready) begin
         // period of 0 or 1 keeps addresses back to back
         if (period <= periodT'(1)) begin
            valid <= 1'b1;
         end else begin
            valid   <= 1'b0;
            waitCnt <= period - periodT'(1);
         end
      end else if (waitCnt != '0) begin
         waitCnt <= waitCnt - periodT'(1);
         if (waitCnt == periodT'(1)) begin
            valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (go) begin
         addr <= start;
      end else if (valid && ready) begin
         addr <= addr + incr;
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      valid && !ready && !go |=> $stable(addr));

endmodule

`default_nettype wire

// File: vread/memoryWriter.sv
`timescale 1ns/1ps
`default_nettype none

module memoryWriter (
   input  logic                clk,
   input  logic                rst,
   input  logic                genValid,
   input  addrGenPkg::bufAddrT genAddr,
   input  logic                busReady,
   input  busPkg::busDataT     busRdata,
   input  logic                busValid,
   output logic                genReady,
   output logic                dataReady,
   output logic                memWrite,
   output addrGenPkg::bufAddrT memAddr,
   output busPkg::busDataT     memData
);
   logic beat;

   // ask for data only while a target address is waiting
   assign dataReady = genValid;

   // transfer needs the address, the request and the bus answer together
   assign beat = genValid & busValid & busReady;

   assign memWrite = beat;
   assign memAddr  = genAddr;
   assign memData  = busRdata;

   // address is consumed exactly when its beat lands
   assign genReady = beat;

   // generator keeps its address up until a beat takes it
   assert property (@(posedge clk) disable iff (rst)
      genValid && !genReady |=> genValid);

   // bus only moves data when there is somewhere to put it
   assert property (@(posedge clk) disable iff (rst)
      busValid && busReady |-> genValid);

endmodule

`default_nettype wire

// File: vread/patternAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module patternAddrGen (
   input  logic                clk,
   input  logic                rst,
   input  logic                go,
   input  addrGenPkg::bufAddrT start,
   input  addrGenPkg::bufAddrT incr,
   input  addrGenPkg::bufAddrT shift,
   input  addrGenPkg::bufAddrT shift2,
   input  addrGenPkg::bufAddrT incr2,
   input  addrGenPkg::bufAddrT iterations,
   input  addrGenPkg::bufAddrT iterations2,
   input  addrGenPkg::periodT  period,
   input  addrGenPkg::periodT  duty,
   input  addrGenPkg::delayT   delay,
   output addrGenPkg::bufAddrT addr,
   output logic                readEn,
   output logic                genDone
);
   import addrGenPkg::*;

   delayT   delayCnt;
   logic    running;
   periodT  stepCnt;
   bufAddrT innerCnt;
   bufAddrT outerCnt;
   bufAddrT innerBase;
   bufAddrT outerBase;
   logic    lastStep;
   logic    lastInner;
   logic    lastOuter;

   // zero counts behave like one
   assign lastStep  = periodT'(stepCnt + 1'b1) >= period;
   assign lastInner = bufAddrT'(innerCnt + 1'b1) >= iterations;
   assign lastOuter = bufAddrT'(outerCnt + 1'b1) >= iterations2;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         running  <= 1'b0;
         delayCnt <= '0;
         stepCnt  <= '0;
         innerCnt <= '0;
         outerCnt <= '0;
      end else if (go) begin
         running  <= (delay == '0);
         delayCnt <= delay;
         stepCnt  <= '0;
         innerCnt <= '0;
         outerCnt <= '0;
      end else if (delayCnt != '0) begin
         delayCnt <= delayCnt - 1'b1;
         if (delayCnt == delayT'(1)) begin
            running <= 1'b1;
         end
      end else if (running) begin
         if (!lastStep) begin
            stepCnt <= stepCnt + 1'b1;
         end else begin
            stepCnt <= '0;
            if (!lastInner) begin
               innerCnt <= innerCnt + 1'b1;
            end else begin
               innerCnt <= '0;
               if (!lastOuter) begin
                  outerCnt <= outerCnt + 1'b1;
               end else begin
                  running <= 1'b0;
               end
            end
         end
      end
   end

   // bases accumulate, so no multipliers are needed
   always_ff @(posedge clk) begin
      if (go) begin
         addr      <= start;
         innerBase <= start;
         outerBase <= start;
      end else if (running) begin
         if (!lastStep) begin
            addr <= addr + incr;
         end else if (!lastInner) begin
            addr      <= innerBase + shift;
            innerBase <= innerBase + shift;
         end else if (!lastOuter) begin
            addr      <= outerBase + shift2;
            innerBase <= outerBase + shift2;
            outerBase <= outerBase + shift2;
         end
      end
   end

   assign readEn  = running & (stepCnt < duty);
   assign genDone = running & lastStep & lastInner & lastOuter;

   assert property (@(posedge clk) disable iff (rst) duty == '0 |-> !readEn);

endmodule

`default_nettype wire

// File: vread/readAligner.sv
`timescale 1ns/1ps
`default_nettype none

module readAligner #(
   parameter int DATA_W = 8
) (
   input  logic                clk,
   input  logic                rst,
   input  addrGenPkg::bufAddrT addrIn,
   input  logic                readEn,
   input  logic                reverse,
   input  logic                pingPong,
   input  busPkg::busDataT     memData,
   output addrGenPkg::bufAddrT memAddr,
   output logic                memRead,
   output logic [DATA_W-1:0]   dataOut,
   output logic                outValid
);
   import busPkg::*;
   import addrGenPkg::*;

   // symbols per buffer word
   localparam int RATIO = BUS_DATA_W / DATA_W;
   localparam int SEL_W = $clog2(RATIO);

   bufAddrT symAddr;

   function automatic bufAddrT reverseBits(input bufAddrT word);
      bufAddrT res;
      for (int k = 0; k < BUF_ADDR_W; k++) begin
         res[k] = word[BUF_ADDR_W-1-k];
      end
      return res;
   endfunction

   // reversal covers the ping-pong bit as well
   assign symAddr = reverse ? reverseBits(addrIn) : addrIn;
   assign memRead = readEn;

   // buffer data arrives one cycle after the read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         outValid <= 1'b0;
      end else begin
         outValid <= readEn;
      end
   end

   generate
      if (RATIO > 1) begin : gNarrow
         logic [SEL_W-1:0] sel;
         bufAddrT          noPingPong;

         always_comb begin
            noPingPong = symAddr;
            noPingPong[BUF_ADDR_W-1] = 1'b0;
            memAddr = noPingPong >> SEL_W;
            memAddr[BUF_ADDR_W-1] = pingPong & symAddr[BUF_ADDR_W-1];
         end

         // select lines up with the registered buffer word
         always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
               sel <= '0;
            end else begin
               sel <= symAddr[SEL_W-1:0];
            end
         end

         assign dataOut = memData[sel*DATA_W +: DATA_W];
      end else begin : gWide
         assign memAddr = symAddr;
         assign dataOut = memData;
      end
   endgenerate

endmodule

`default_nettype wire

// File: vread/vreadCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module vreadCtrl (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  logic                disabled,
   input  logic                pingPong,
   input  busPkg::busAddrT     extAddr,
   input  addrGenPkg::bufAddrT startB,
   input  logic                busLast,
   input  logic                busReady,
   input  logic                dataReady,
   input  logic                genDone,
   output logic                go,
   output logic                done,
   output logic                busValid,
   output busPkg::busAddrT     busAddr,
   output addrGenPkg::bufAddrT writeStart,
   output addrGenPkg::bufAddrT readStart
);
   import addrGenPkg::*;

   logic doneA;
   logic doneB;
   logic pingPongState;

   assign go = run & ~disabled;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pingPongState <= 1'b0;
      end else if (go) begin
         pingPongState <= pingPong & ~pingPongState;
      end
   end

   // write side fills the half the read side is not using
   always_comb begin
      writeStart = '0;
      writeStart[BUF_ADDR_W-1] = ~pingPongState;
   end

   always_comb begin
      readStart = startB;
      if (pingPong) begin
         readStart[BUF_ADDR_W-1] = pingPongState;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busAddr <= '0;
      end else if (go) begin
         busAddr <= extAddr;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         doneA <= 1'b1;
         doneB <= 1'b1;
      end else if (go) begin
         doneA <= 1'b0;
         doneB <= 1'b0;
      end else begin
         if (busValid && busReady && busLast) begin
            doneA <= 1'b1;
         end
         if (genDone) begin
            doneB <= 1'b1;
         end
      end
   end

   assign busValid = dataReady & ~doneA;
   assign done     = doneA & doneB;

   // no bus request once the burst is complete
   assert property (@(posedge clk) disable iff (rst) doneA |-> !busValid);

   // a run can only start through go
   assert property (@(posedge clk) disable iff (rst) $fell(done) |-> $past(go));

endmodule

`default_nettype wire
